// File: common/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath word and byte address width
`define DATA_W 32

// Register index for 32 general purpose registers
`define REG_ADDR_W 5

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

`endif

// File: common/mips_pkg.sv
`include "mips_macros.svh"

package mips_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001, // Only bgez of this group
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_JR   = 6'b001000,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_FUNCT = 4'b0000, // R-type decodes funct
        ALU_ADD   = 4'b0001,
        ALU_ADDU  = 4'b0010,
        ALU_AND   = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_OR    = 4'b0101,
        ALU_LUI   = 4'b0111,
        ALU_SUB   = 4'b1000
    } alu_op_e;

    // 1xx codes match the low opcode bits of 0001xx
    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_BGEZ = 3'b001,
        BR_BEQ  = 3'b100,
        BR_BNE  = 3'b101,
        BR_BLEZ = 3'b110,
        BR_BGTZ = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        JMP_NONE = 2'b00,
        JMP_J    = 2'b01,
        JMP_JAL  = 2'b10
    } jump_e;

endpackage

// File: compile.f
+incdir+common
common/mips_pkg.sv
hw/control.sv
hw/alu.sv
hw/reg_file.sv
hw/branch_unit.sv
hw/mips_core.sv
dv/tb_mips_core.sv

// File: dv/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    localparam logic [31:0] DONE_ADDR = 32'h0000_03FC;
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_we;
    logic        dmem_re;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] st_addr [$]; // All stores but the done marker
    logic [31:0] st_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [15:0] lfsr;
    int          done_count;
    int          re_cycles;
    int          we_cycles;
    int          mon_errors;
    int          errors;
    int          tests;
    int          failed_tests;
    int          prog_len;
    int          store_base;
    int          done_base;
    int          re_base;
    int          we_base;

    mips_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Data memory writes and strobe bookkeeping at mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!dmem_re || imem_data[31:26] == OP_LW) else begin
                $display("dmem_re is high in a cycle that does not execute lw");
                mon_errors++;
            end
            assert (!dmem_we || imem_data[31:26] == OP_SW) else begin
                $display("dmem_we is high in a cycle that does not execute sw");
                mon_errors++;
            end
        end else begin
            assert (!dmem_we && !dmem_re) else begin
                $display("a memory strobe is active while rst_n is low");
                mon_errors++;
            end
        end
        if (dmem_re) begin
            re_cycles++;
        end
        if (dmem_we) begin
            we_cycles++;
            dmem[dmem_addr[9:2]] = dmem_wdata;
            if (dmem_addr == DONE_ADDR) begin
                done_count++;
            end else begin
                st_addr.push_back(dmem_addr);
                st_data.push_back(dmem_wdata);
            end
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // Galois step
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(funct_e f, int rs, int rt, int rd, int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
    endfunction

    function automatic logic [31:0] i_type(opcode_e op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] rtype_ref(funct_e f, logic [31:0] a, logic [31:0] b,
                                              int sh);
        case (f)
            F_SLL: return b << sh[4:0];
            F_SRL: return b >> sh[4:0];
            F_SRA: return $signed(b) >>> sh[4:0];
            F_ADD, F_ADDU: return a + b;
            F_SUB, F_SUBU: return a - b;
            F_AND: return a & b;
            F_OR: return a | b;
            F_XOR: return a ^ b;
            F_NOR: return ~(a | b);
            F_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0; // sltu
        endcase
    endfunction

    function automatic bit branch_taken(opcode_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_BEQ: return a == b;
            OP_BNE: return a != b;
            OP_BLEZ: return $signed(a) <= 0;
            OP_BGTZ: return $signed(a) > 0;
            default: return $signed(a) >= 0; // regimm taken as bgez
        endcase
    endfunction

    task automatic emit(logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic begin_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = r_type(F_SLL, i, i >> 5, 0, 0); // Nop with the address in rs and rt
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic end_program();
        emit(i_type(OP_SW, 0, 0, DONE_ADDR));
        emit(i_type(OP_BEQ, 0, 0, -1)); // Spin here
    endtask

    task automatic load_reg(int r, logic [31:0] v);
        emit(i_type(OP_LUI, 0, r, v >> 16));
        emit(i_type(OP_ORI, r, r, v));
    endtask

    task automatic expect_store(logic [31:0] a, logic [31:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic reset_cpu();
        @(posedge clk);
        #10 rst_n = 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic release_cpu();
        #10 rst_n = 1'b1;
        store_base = st_addr.size();
        done_base  = done_count;
        re_base    = re_cycles;
        we_base    = we_cycles;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_count == done_base && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (done_count == done_base) begin
            $display("Timeout: no store to the done address within %0d cycles",
                     TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    task automatic run_program();
        reset_cpu();
        release_cpu();
        wait_done();
    endtask

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_stores();
        int n;
        n = st_addr.size() - store_base;
        check_word("store_count", exp_addr.size(), n);
        for (int i = 0; i < n && i < exp_addr.size(); i++) begin
            check_word("dmem_addr", exp_addr[i], st_addr[store_base + i]);
            check_word("dmem_wdata", exp_data[i], st_data[store_base + i]);
        end
    endtask

    task automatic finish_test(string name, int err_before);
        tests++;
        if (errors + mon_errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors + mon_errors - err_before);
        end
    endtask

    task automatic test_immediate();
        opcode_e     ops [6];
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] e;
        int          e0;
        e0 = errors + mon_errors;
        ops = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        begin_program();
        a = rand_bits(32);
        load_reg(1, a);
        for (int i = 0; i < 6; i++) begin
            imm = 32'h8000 | rand_bits(15); // Top bit set
            case (ops[i])
                OP_ADDI, OP_ADDIU: e = a + {{16{imm[15]}}, imm[15:0]};
                OP_ANDI: e = a & imm;
                OP_ORI: e = a | imm;
                OP_XORI: e = a ^ imm;
                default: e = {imm[15:0], 16'h0000};
            endcase
            emit(i_type(ops[i], 1, 2, imm));
            emit(i_type(OP_SW, 0, 2, i * 4));
            expect_store(i * 4, e);
        end
        end_program();
        run_program();
        check_stores();
        finish_test("immediate ops", e0);
    endtask

    task automatic test_rtype();
        funct_e      fl [13];
        logic [31:0] a;
        logic [31:0] b;
        int          sh;
        int          addr;
        int          e0;
        e0 = errors + mon_errors;
        fl = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU,
               F_SLL, F_SRL, F_SRA};
        begin_program();
        addr = 0;
        for (int p = 0; p < 2; p++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            if (p == 0) begin
                b[31] = 1'b1; // Negative b so sra differs from srl
            end else begin
                a[31] = 1'b1; // Negative against positive
                b[31] = 1'b0;
            end
            load_reg(1, a);
            load_reg(2, b);
            for (int k = 0; k < 13; k++) begin
                sh = 0;
                if (k >= 10) begin
                    sh = rand_bits(5);
                    if (sh == 0) begin
                        sh = 31;
                    end
                end
                emit(r_type(fl[k], 1, 2, 3, sh));
                emit(i_type(OP_SW, 0, 3, addr));
                expect_store(addr, rtype_ref(fl[k], a, b, sh));
                addr += 4;
            end
        end
        emit(r_type(F_OR, 1, 2, 0, 0)); // Aimed at r0
        emit(i_type(OP_SW, 0, 0, addr));
        expect_store(addr, 32'h0);
        end_program();
        run_program();
        check_stores();
        finish_test("r-type ops", e0);
    endtask

    task automatic test_memory();
        logic [31:0] vals [3];
        int          e0;
        e0 = errors + mon_errors;
        begin_program();
        for (int i = 0; i < 3; i++) begin
            vals[i] = rand_bits(32);
            load_reg(i + 1, vals[i]);
            emit(i_type(OP_SW, 0, i + 1, 'h40 + i * 4));
            expect_store('h40 + i * 4, vals[i]);
        end
        for (int i = 0; i < 3; i++) begin
            emit(i_type(OP_LW, 0, i + 4, 'h40 + i * 4));
        end
        for (int i = 0; i < 3; i++) begin
            emit(i_type(OP_SW, 0, i + 4, 'h80 + i * 4));
            expect_store('h80 + i * 4, vals[i]);
        end
        end_program();
        run_program();
        check_stores();
        check_word("dmem_re_cycles", 3, re_cycles - re_base);
        check_word("dmem_we_cycles", 7, we_cycles - we_base); // Six plus the done store
        finish_test("load and store", e0);
    endtask

    task automatic test_branch();
        opcode_e     ops [10];
        logic [31:0] av [10];
        logic [31:0] bv [10];
        logic [31:0] neg;
        logic [31:0] pos;
        int          rt;
        int          e0;
        e0 = errors + mon_errors;
        neg = rand_bits(32) | 32'h8000_0000;
        pos = rand_bits(31) | 32'h1;
        ops = '{OP_BEQ, OP_BEQ, OP_BNE, OP_BNE, OP_BLEZ, OP_BLEZ, OP_BGTZ, OP_BGTZ,
                OP_REGIMM, OP_REGIMM};
        av = '{neg, neg, neg, neg, 32'h0, pos, pos, neg, 32'h0, neg};
        bv = '{neg, pos, pos, neg, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
        begin_program();
        for (int i = 0; i < 10; i++) begin
            rt = 0;
            if (ops[i] == OP_BEQ || ops[i] == OP_BNE) begin
                rt = 2;
            end else if (ops[i] == OP_REGIMM) begin
                rt = 1; // bgez
            end
            load_reg(1, av[i]);
            load_reg(2, bv[i]);
            emit(i_type(ops[i], 1, rt, 2));
            emit(i_type(OP_SW, 0, 0, i * 8)); // Not-taken marker
            emit(i_type(OP_BEQ, 0, 0, 1));
            emit(i_type(OP_SW, 0, 0, i * 8 + 4)); // Taken marker
            expect_store(branch_taken(ops[i], av[i], bv[i]) ? i * 8 + 4 : i * 8, 32'h0);
        end
        end_program();
        run_program();
        check_stores();
        finish_test("branches", e0);
    endtask

    task automatic test_jump();
        int e0;
        e0 = errors + mon_errors;
        begin_program();
        emit({OP_J, 26'd2});
        emit(i_type(OP_SW, 0, 0, 'h10)); // Skipped by j
        emit({OP_JAL, 26'd5});
        emit(i_type(OP_SW, 0, 0, 'h14)); // jr lands here
        emit({OP_J, 26'd7});
        emit(i_type(OP_SW, 0, 31, 'h18));
        emit(r_type(F_JR, 31, 0, 0, 0));
        end_program();
        expect_store('h18, 'h08 + 4); // jal sits at 0x08
        expect_store('h14, 32'h0);
        run_program();
        check_stores();
        finish_test("jumps", e0);
    endtask

    task automatic test_reset();
        logic [31:0] acc;
        logic [31:0] imm;
        int          n;
        int          cyc;
        int          e0;
        e0 = errors + mon_errors;
        begin_program();
        acc = '0;
        for (int k = 0; k < 8; k++) begin
            imm = rand_bits(16);
            emit(i_type(OP_ADDIU, 5, 5, imm)); // r5 accumulates from its reset value
            emit(i_type(OP_SW, 0, 5, k * 4));
            acc = acc + {{16{imm[15]}}, imm[15:0]};
            expect_store(k * 4, acc);
        end
        end_program();
        run_program();
        check_stores();
        reset_cpu();
        release_cpu();
        cyc = 0;
        while (st_addr.size() - store_base < 3 && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (st_addr.size() - store_base < 3) begin
            $display("Timeout waiting for stores before the mid-program reset");
            errors++;
        end
        @(posedge clk); // Reset lands on the fourth sw
        #10 rst_n = 1'b0;
        n = st_addr.size();
        repeat (8) @(posedge clk);
        check_word("stores_in_reset", 0, st_addr.size() - n);
        release_cpu();
        wait_done();
        check_stores(); // Same sequence as the first run
        finish_test("reset in mid-program", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        lfsr  = 16'd50342;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hD000_0000 | i;
        end
        begin_program();
        test_immediate();
        test_rtype();
        test_memory();
        test_branch();
        test_jump();
        test_reset();
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module alu import mips_pkg::*; (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  alu_op_e            alu_op,
    input  funct_e             func,
    output logic [`DATA_W-1:0] result
);

    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        result = '0;
        case (alu_op)
            ALU_FUNCT: begin
                case (func)
                    F_SLL: begin
                        result = b << shamt;
                    end
                    F_SRL: begin
                        result = b >> shamt;
                    end
                    F_SRA: begin
                        result = $signed(b) >>> shamt;
                    end
                    F_ADD, F_ADDU: begin
                        result = a + b; // Wraps without an overflow trap
                    end
                    F_SUB, F_SUBU: begin
                        result = a - b;
                    end
                    F_AND: begin
                        result = a & b;
                    end
                    F_OR: begin
                        result = a | b;
                    end
                    F_XOR: begin
                        result = a ^ b;
                    end
                    F_NOR: begin
                        result = ~(a | b);
                    end
                    F_SLT: begin
                        result = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
                    end
                    F_SLTU: begin
                        result = {{(`DATA_W-1){1'b0}}, a < b};
                    end
                    default: begin
                        result = '0; // jr and unknown functs
                    end
                endcase
            end
            ALU_ADD, ALU_ADDU: begin
                result = a + b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            ALU_SUB: begin
                result = a - b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module branch_unit import mips_pkg::*; (
    input  logic [`DATA_W-1:0] pc_plus4,
    input  logic [`DATA_W-1:0] rs_data,
    input  logic [`DATA_W-1:0] rt_data,
    input  logic [`DATA_W-1:0] imm_ext,
    input  logic [25:0]        jump_index,
    input  branch_e            branch,
    input  jump_e              jump,
    input  logic               jr,
    output logic [`DATA_W-1:0] next_pc
);

    logic               taken;
    logic signed [`DATA_W-1:0] rs_s;
    logic [`DATA_W-1:0] br_target;
    logic [`DATA_W-1:0] j_target;

    assign rs_s = $signed(rs_data);

    always_comb begin
        case (branch)
            BR_BEQ:  taken = (rs_data == rt_data);
            BR_BNE:  taken = (rs_data != rt_data);
            BR_BLEZ: taken = (rs_s <= 0);
            BR_BGTZ: taken = (rs_s > 0);
            BR_BGEZ: taken = (rs_s >= 0);
            default: taken = 1'b0;
        endcase
    end

    assign br_target = pc_plus4 + (imm_ext << 2);
    assign j_target  = {pc_plus4[31:28], jump_index, 2'b00}; // Same 256MB region

    always_comb begin
        if (jr) begin
            next_pc = rs_data;
        end else if (jump != JMP_NONE) begin
            next_pc = j_target;
        end else if (taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

// File: hw/control.sv
`timescale 1ns/1ps

module control import mips_pkg::*; (
    input  opcode_e     opcode,
    input  funct_e      func,
    output logic        reg_dst,
    output logic [1:0]  alu_src,
    output logic        mem_to_reg,
    output logic        reg_write,
    output logic        mem_read,
    output logic        mem_write,
    output branch_e     branch,
    output alu_op_e     alu_op,
    output logic        jr,
    output jump_e       jump,
    output logic        do_extend
);

    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 2'b00; // Bit 0 picks shamt for a, bit 1 picks imm for b
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = BR_NONE;
        alu_op     = ALU_FUNCT;
        jr         = 1'b0;
        jump       = JMP_NONE;
        do_extend  = 1'b1;

        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (func)
                    F_SLL, F_SRL, F_SRA: begin
                        alu_src[0] = 1'b1; // Shift by shamt field
                    end
                    F_JR: begin
                        jr        = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
            OP_ADDI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_ADD;
            end
            OP_ADDIU: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_ADDU;
            end
            OP_ANDI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_AND;
                do_extend = 1'b0;
            end
            OP_ORI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_OR;
                do_extend = 1'b0;
            end
            OP_XORI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_XOR;
                do_extend = 1'b0;
            end
            OP_LUI: begin
                alu_src   = 2'b10;
                reg_write = 1'b1;
                alu_op    = ALU_LUI;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                branch = branch_e'(opcode[2:0]);
                alu_op = ALU_SUB;
            end
            OP_REGIMM: begin
                branch = BR_BGEZ; // rt field not looked at
            end
            OP_J: begin
                jump = JMP_J;
            end
            OP_JAL: begin
                jump      = JMP_JAL;
                reg_write = 1'b1; // Link into r31
            end
            OP_LW: begin
                alu_src    = 2'b10;
                reg_write  = 1'b1;
                alu_op     = ALU_ADD;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 2'b10;
                alu_op    = ALU_ADD;
                mem_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core import mips_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`DATA_W-1:0] imem_data,
    input  logic [`DATA_W-1:0] dmem_rdata,
    output logic [`DATA_W-1:0] imem_addr,
    output logic [`DATA_W-1:0] dmem_addr,
    output logic [`DATA_W-1:0] dmem_wdata,
    output logic               dmem_we,
    output logic               dmem_re
);

    logic [`DATA_W-1:0]     pc;
    logic [`DATA_W-1:0]     pc_plus4;
    logic [`DATA_W-1:0]     next_pc;

    // Instruction fields
    opcode_e                opcode;
    funct_e                 funct;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [15:0]            imm;
    logic [25:0]            jump_index;

    logic                   reg_dst;
    logic [1:0]             alu_src;
    logic                   mem_to_reg;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    branch_e                branch;
    alu_op_e                alu_op;
    logic                   jr;
    jump_e                  jump;
    logic                   do_extend;

    logic [`DATA_W-1:0]     imm_ext;
    logic [`DATA_W-1:0]     rs_data;
    logic [`DATA_W-1:0]     rt_data;
    logic [`DATA_W-1:0]     alu_a;
    logic [`DATA_W-1:0]     alu_b;
    logic [`DATA_W-1:0]     alu_result;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0]     wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign pc_plus4  = pc + `DATA_W'd4;
    assign imem_addr = pc;

    assign opcode     = opcode_e'(imem_data[31:26]);
    assign rs         = imem_data[25:21];
    assign rt         = imem_data[20:16];
    assign rd         = imem_data[15:11];
    assign shamt      = imem_data[10:6];
    assign funct      = funct_e'(imem_data[5:0]);
    assign imm        = imem_data[15:0];
    assign jump_index = imem_data[25:0];

    assign imm_ext = do_extend ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    assign alu_a = alu_src[0] ? {{(`DATA_W-5){1'b0}}, shamt} : rs_data;
    assign alu_b = alu_src[1] ? imm_ext : rt_data;

    // jal links into r31
    assign wr_addr = (jump == JMP_JAL) ? `REG_ADDR_W'd31 : (reg_dst ? rd : rt);
    assign wr_data = mem_to_reg ? dmem_rdata :
                     (jump == JMP_JAL) ? pc_plus4 : alu_result;

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rt_data;
    assign dmem_we    = mem_write & rst_n; // Quiet during reset
    assign dmem_re    = mem_read & rst_n;

    control u_control (
        .opcode     (opcode),
        .func       (funct),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .alu_op     (alu_op),
        .jr         (jr),
        .jump       (jump),
        .do_extend  (do_extend)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .wr_addr (wr_addr),
        .wr_en   (reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .alu_op (alu_op),
        .func   (funct),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .pc_plus4   (pc_plus4),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm_ext    (imm_ext),
        .jump_index (jump_index),
        .branch     (branch),
        .jump       (jump),
        .jr         (jr),
        .next_pc    (next_pc)
    );

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic                   wr_en,
    input  logic [`DATA_W-1:0]     wr_data,
    output logic [`DATA_W-1:0]     rs_data,
    output logic [`DATA_W-1:0]     rt_data
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // r0 never written
        end
    end

    // r0 hardwired to zero on both read ports
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_mips_core -o tb_mips_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mips_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0
